// File: dv/sequence_correction_tb.sv
`include "seq_consts.svh"

module sequence_correction_tb
    import symbol_pkg::*, error_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CW = `CHANNEL_WIDTH;
    localparam int SW = `SUBFRAME_WIDTH;
    localparam int PD = `PATTERN_DEPTH;

    typedef struct packed {
        logic                valid;
        logic                quiet;
        symbol_t    [CW-1:0] sym;
        res_error_t [CW-1:0] res;
        adjust_t    [CW-1:0] adj;
    } expect_t;

    logic       clk;
    logic       rst_n_i;
    logic       valid_i;
    symbol_t    symbols_i          [CW-1:0];
    res_error_t res_errors_i       [CW-1:0];
    branch_t    trellis_patterns_i [`NUM_PATTERNS-1:0][PD-1:0];
    logic       valid_o;
    symbol_t    symbols_o          [CW-1:0];
    res_error_t res_errors_o       [CW-1:0];
    adjust_t    symbol_adjust_o    [CW-1:0];

    int      pat_w [`NUM_PATTERNS][PD] = '{'{1, -1}, '{1, 1}, '{1, 0}, '{-1, 1}};
    int      stim_sym [CW];
    int      stim_res [CW];
    int      seed = 32'h365e;
    int      sent_count = 0;
    int      out_count = 0;
    bit      seen_valid = 1'b0;
    bit      check_en = 1'b0;
    expect_t exp_q [$];
    expect_t exp_cur = '0;

    sequence_correction_top u_sequence_correction_top (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .valid_i           (valid_i),
        .symbols_i         (symbols_i),
        .res_errors_i      (res_errors_i),
        .trellis_patterns_i(trellis_patterns_i),
        .valid_o           (valid_o),
        .symbols_o         (symbols_o),
        .res_errors_o      (res_errors_o),
        .symbol_adjust_o   (symbol_adjust_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        for (int i = 0; i < 4000; i++) begin
            @(posedge clk);
        end
        $display("simulation did not finish within 4000 cycles");
        $display("Test failures found");
        $fatal(1, "watchdog timeout");
    end

    always @(negedge clk) begin
        if (valid_o) begin
            out_count++;
        end
    end

    // reference for one frame built from the detector, locator and corrector rules
    function automatic expect_t model_frame(logic v);
        int      flag [CW];
        int      ener [CW];
        int      adj  [CW];
        int      m;
        int      mag;
        int      best;
        int      code;
        int      win;
        int      p;
        int      sgn;
        int      s_val;
        expect_t e;

        code = 0;
        for (int l = 0; l < CW; l++) begin
            best = 0;
            flag[l] = 0;
            ener[l] = 0;
            adj[l] = 0;
            for (int q = 0; q < `NUM_PATTERNS; q++) begin
                m = 0;
                for (int k = 0; k < PD && l + k < CW; k++) begin
                    m += pat_w[q][k] * stim_res[l + k];
                end
                mag = (m < 0) ? -m : m;
                if (mag > best) begin
                    best = mag;
                    code = (m < 0) ? 2 * q + 2 : 2 * q + 1;
                end
            end
            if (best >= `FLAG_THRESH) begin
                flag[l] = code;
                ener[l] = (best > 255) ? 255 : best;
            end
        end
        for (int s = 0; s < CW; s += SW) begin
            win = -1;
            for (int i = 0; i < SW; i++) begin
                if (flag[s + i] != 0 && (win < 0 || ener[s + i] > ener[s + win])) begin
                    win = i;
                end
            end
            if (win >= 0) begin
                p = (flag[s + win] - 1) / 2;
                sgn = (flag[s + win] % 2 == 1) ? 1 : -1;
                for (int k = 0; k < PD && win + k < SW; k++) begin
                    adj[s + win + k] = sgn * pat_w[p][k];
                end
            end
        end
        e.valid = v;
        e.quiet = !seen_valid;
        for (int l = 0; l < CW; l++) begin
            s_val = stim_sym[l] + adj[l];
            s_val = (s_val < 0) ? 0 : ((s_val > 3) ? 3 : s_val);
            e.sym[l] = symbol_t'(s_val);
            e.res[l] = res_error_t'(stim_res[l]);
            e.adj[l] = adjust_t'(adj[l]);
        end
        return e;
    endfunction

    task automatic report_mismatch(input string name, input int exp_v, input int act_v);
        $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        $display("Test failures found");
        $fatal(1, "output mismatch");
    endtask

    task automatic drive_frame(input logic v);
        expect_t e;
        @(negedge clk);
        valid_i = v;
        for (int l = 0; l < CW; l++) begin
            symbols_i[l]    = symbol_t'(stim_sym[l]);
            res_errors_i[l] = res_error_t'(stim_res[l]);
        end
        if (v) begin
            seen_valid = 1'b1;
            sent_count++;
        end
        e = model_frame(v);
        // a frame taken in while reset is low is cleared in every stage
        if (!rst_n_i) begin
            e = '0;
            e.quiet = 1'b1;
        end
        exp_q.push_back(e);
        // three frames are in flight, so the fourth newest sits on the outputs
        if (exp_q.size() > 3) begin
            exp_cur = exp_q.pop_front();
        end
    endtask

    task automatic clear_frame(input int fill);
        for (int l = 0; l < CW; l++) begin
            stim_sym[l] = fill;
            stim_res[l] = 0;
        end
    endtask

    task automatic add_error(input int lane, input int p, input int amp);
        for (int k = 0; k < PD && lane + k < CW; k++) begin
            stim_res[lane + k] += amp * pat_w[p][k];
        end
    endtask

    task automatic random_frame(input int spread);
        for (int l = 0; l < CW; l++) begin
            stim_sym[l] = $random(seed) & 3;
            stim_res[l] = $random(seed) % spread;
        end
    endtask

    task automatic idle_frames(input int n);
        for (int i = 0; i < n; i++) begin
            random_frame(128);
            drive_frame(1'b0);
        end
    endtask

    task automatic wait_for_outputs();
        int cycles;
        cycles = 0;
        clear_frame(0);
        while (out_count != sent_count) begin
            if (cycles > 10) begin
                $display("valid_o did not deliver all frames within 10 idle cycles");
                $display("Test failures found");
                $fatal(1, "drain timeout");
            end else begin
                drive_frame(1'b0);
                cycles++;
            end
        end
        // one more rising edge so the last frame reaches its comparison
        drive_frame(1'b0);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (!check_en)
        valid_o == exp_cur.valid)
        else report_mismatch("valid_o", int'($sampled(exp_cur.valid)), int'($sampled(valid_o)));

    // data lanes are compared for valid frames and for the idle stretch before the first one
    for (genvar l = 0; l < CW; l++) begin : g_lane_check
        a_symbol: assert property (@(posedge clk) disable iff (!check_en)
            (valid_o || exp_cur.quiet) |-> (symbols_o[l] == exp_cur.sym[l]))
            else report_mismatch($sformatf("symbols_o[%0d]", l),
                int'($sampled(exp_cur.sym[l])), int'($sampled(symbols_o[l])));
        a_residual: assert property (@(posedge clk) disable iff (!check_en)
            (valid_o || exp_cur.quiet) |-> (res_errors_o[l] == exp_cur.res[l]))
            else report_mismatch($sformatf("res_errors_o[%0d]", l),
                int'($signed($sampled(exp_cur.res[l]))), int'($signed($sampled(res_errors_o[l]))));
        a_adjust: assert property (@(posedge clk) disable iff (!check_en)
            (valid_o || exp_cur.quiet) |-> (symbol_adjust_o[l] == exp_cur.adj[l]))
            else report_mismatch($sformatf("symbol_adjust_o[%0d]", l),
                int'($signed($sampled(exp_cur.adj[l]))),
                int'($signed($sampled(symbol_adjust_o[l]))));
    end

    initial begin
        int gap;

        rst_n_i = 1'b0;
        valid_i = 1'b0;
        for (int p = 0; p < `NUM_PATTERNS; p++) begin
            for (int k = 0; k < PD; k++) begin
                trellis_patterns_i[p][k] = branch_t'(pat_w[p][k]);
            end
        end
        clear_frame(0);
        for (int l = 0; l < CW; l++) begin
            symbols_i[l]    = '0;
            res_errors_i[l] = '0;
        end

        // the first reset edge has cleared every register before checking starts
        // junk data during reset must not reach the outputs
        for (int c = 0; c < 15; c++) begin
            random_frame(128);
            drive_frame(1'b0);
            check_en = 1'b1;
        end
        // reset is gone by the edge that takes in this last frame, so it stays quiet
        clear_frame(0);
        drive_frame(1'b0);
        rst_n_i = 1'b1;
        for (int c = 0; c < 6; c++) begin
            drive_frame(1'b0);
        end

        // small residuals stay below the threshold
        for (int c = 0; c < 3; c++) begin
            random_frame(3);
            drive_frame(1'b1);
        end
        idle_frames(2);

        // single patterns with clamping at both ends, a clipped one at lane 7, a saturated energy
        clear_frame(3);
        add_error(3, 0, 20);
        drive_frame(1'b1);
        clear_frame(0);
        add_error(3, 0, 20);
        drive_frame(1'b1);
        clear_frame(0);
        add_error(7, 1, -30);
        drive_frame(1'b1);
        clear_frame(3);
        add_error(7, 3, 25);
        drive_frame(1'b1);
        clear_frame(1);
        add_error(10, 1, -128);
        drive_frame(1'b1);
        idle_frames(3);

        // competing flags, larger energy in subframe 0 and equal energies in subframe 1
        clear_frame(2);
        add_error(1, 0, 12);
        add_error(5, 0, 30);
        add_error(9, 1, 20);
        add_error(13, 1, 20);
        drive_frame(1'b1);
        clear_frame(1);
        add_error(0, 3, 10);
        add_error(4, 0, 30);
        add_error(11, 2, -15);
        drive_frame(1'b1);

        for (int n = 0; n < 200; n++) begin
            gap = $random(seed) & 7;
            idle_frames(gap > 3 ? 0 : gap);
            random_frame(128);
            drive_frame(1'b1);
        end

        wait_for_outputs();
        if (out_count != sent_count || sent_count == 0) begin
            $display("%0d frames sent but %0d came out", sent_count, out_count);
            $display("Test failures found");
            $fatal(1, "frame count mismatch");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule : sequence_correction_tb

// File: logic/error_flag_detector.sv
`include "seq_consts.svh"

module error_flag_detector
    import symbol_pkg::*, error_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  res_error_t res_errors_i       [`CHANNEL_WIDTH-1:0],
    input  branch_t    trellis_patterns_i [`NUM_PATTERNS-1:0][`PATTERN_DEPTH-1:0],
    output logic       valid_o,
    output flag_t      flags_o            [`CHANNEL_WIDTH-1:0],
    output energy_t    flag_ener_o        [`CHANNEL_WIDTH-1:0]
);

    localparam int PIDX_W    = $clog2(`NUM_PATTERNS);
    localparam int PAD_LANES = `CHANNEL_WIDTH + `PATTERN_DEPTH - 1;

    res_error_t res_pad [PAD_LANES-1:0];
    flag_t      flag_d  [`CHANNEL_WIDTH-1:0];
    energy_t    ener_d  [`CHANNEL_WIDTH-1:0];

    // patterns never reach into the next frame, so lanes past the end read as zero
    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            res_pad[i] = res_errors_i[i];
        end
        for (int i = `CHANNEL_WIDTH; i < PAD_LANES; i++) begin
            res_pad[i] = '0;
        end
    end

    for (genvar l = 0; l < `CHANNEL_WIDTH; l++) begin : g_lane
        metric_t           metric [`NUM_PATTERNS-1:0];
        logic [9:0]        mag    [`NUM_PATTERNS-1:0];
        logic [9:0]        best_mag;
        logic [PIDX_W-1:0] best_p;
        logic              best_neg;
        flag_t             lane_flag;
        energy_t           lane_ener;

        always_comb begin
            for (int p = 0; p < `NUM_PATTERNS; p++) begin
                metric[p] = '0;
                for (int k = 0; k < `PATTERN_DEPTH; k++) begin
                    metric[p] = metric[p] + metric_t'(trellis_patterns_i[p][k])
                                          * metric_t'(res_pad[l + k]);
                end
                mag[p] = metric[p][9] ? 10'(-metric[p]) : 10'(metric[p]);
            end
        end

        // strict compare keeps the lowest pattern index on a tie
        always_comb begin
            best_mag = mag[0];
            best_p   = '0;
            best_neg = metric[0][9];
            for (int p = 1; p < `NUM_PATTERNS; p++) begin
                if (mag[p] > best_mag) begin
                    best_mag = mag[p];
                    best_p   = PIDX_W'(p);
                    best_neg = metric[p][9];
                end
            end
        end

        always_comb begin
            if (best_mag >= 10'(`FLAG_THRESH)) begin
                lane_flag = flag_t'(2 * best_p + (best_neg ? 2 : 1));
                lane_ener = (best_mag > 10'd255) ? 8'hff : best_mag[7:0];
            end else begin
                lane_flag = '0;
                lane_ener = '0;
            end
        end

        assign flag_d[l] = lane_flag;
        assign ener_d[l] = lane_ener;

        // the locator relies on every flagged lane carrying a real energy
        a_flag_has_energy: assert property (@(posedge clk) disable iff (!rst_n_i)
            (flags_o[l] != '0) |-> (flag_ener_o[l] >= energy_t'(`FLAG_THRESH)));
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                flags_o[i]     <= '0;
                flag_ener_o[i] <= '0;
            end
        end else begin
            valid_o <= valid_i;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                flags_o[i]     <= flag_d[i];
                flag_ener_o[i] <= ener_d[i];
            end
        end
    end

endmodule : error_flag_detector

// File: logic/error_pkg.sv
package error_pkg;

    // residual error left by the detector for one lane
    typedef logic signed [7:0] res_error_t;

    // correlation of residuals with one pattern
    // two terms of at most 128 each fit with room to spare
    typedef logic signed [9:0] metric_t;

    // absolute metric saturated at 255
    typedef logic [7:0] energy_t;

endpackage : error_pkg

// File: logic/seq_consts.svh
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// lanes carried by one frame
`define CHANNEL_WIDTH 16

// lanes searched together by the locator
`define SUBFRAME_WIDTH 8

// trellis error patterns and the number of lanes each one spans
`define NUM_PATTERNS 4
`define PATTERN_DEPTH 2

// smallest absolute correlation metric that raises a flag
`define FLAG_THRESH 6

// holds flag codes 0 to 2*NUM_PATTERNS
`define FLAG_WIDTH 4

`endif

// File: logic/sequence_correction_top.sv
`include "seq_consts.svh"

module sequence_correction_top
    import symbol_pkg::*, error_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  symbol_t    symbols_i          [`CHANNEL_WIDTH-1:0],
    input  res_error_t res_errors_i       [`CHANNEL_WIDTH-1:0],
    input  branch_t    trellis_patterns_i [`NUM_PATTERNS-1:0][`PATTERN_DEPTH-1:0],
    output logic       valid_o,
    output symbol_t    symbols_o          [`CHANNEL_WIDTH-1:0],
    output res_error_t res_errors_o       [`CHANNEL_WIDTH-1:0],
    output adjust_t    symbol_adjust_o    [`CHANNEL_WIDTH-1:0]
);

    logic       det_valid;
    flag_t      det_flags   [`CHANNEL_WIDTH-1:0];
    energy_t    det_ener    [`CHANNEL_WIDTH-1:0];

    logic       dp_valid;
    symbol_t    dp_symbols  [`CHANNEL_WIDTH-1:0];
    res_error_t dp_res      [`CHANNEL_WIDTH-1:0];
    adjust_t    dp_adjust   [`CHANNEL_WIDTH-1:0];

    error_flag_detector u_error_flag_detector (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .valid_i           (valid_i),
        .res_errors_i      (res_errors_i),
        .trellis_patterns_i(trellis_patterns_i),
        .valid_o           (det_valid),
        .flags_o           (det_flags),
        .flag_ener_o       (det_ener)
    );

    // raw symbols and residuals go straight in, the datapath lines them up with the flags
    symbol_adjust_locator_datapath u_symbol_adjust_locator_datapath (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .valid_i           (det_valid),
        .flags_i           (det_flags),
        .flag_ener_i       (det_ener),
        .symbols_i         (symbols_i),
        .res_errors_i      (res_errors_i),
        .trellis_patterns_i(trellis_patterns_i),
        .valid_o           (dp_valid),
        .symbols_o         (dp_symbols),
        .res_errors_o      (dp_res),
        .symbol_adjust_o   (dp_adjust)
    );

    symbol_corrector u_symbol_corrector (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .valid_i        (dp_valid),
        .symbols_i      (dp_symbols),
        .res_errors_i   (dp_res),
        .symbol_adjust_i(dp_adjust),
        .valid_o        (valid_o),
        .symbols_o      (symbols_o),
        .res_errors_o   (res_errors_o),
        .symbol_adjust_o(symbol_adjust_o)
    );

endmodule : sequence_correction_top

// File: logic/symbol_adjust_locator.sv
`include "seq_consts.svh"

module symbol_adjust_locator
    import symbol_pkg::*, error_pkg::*;
(
    input  flag_t   flags_i            [`CHANNEL_WIDTH-1:0],
    input  energy_t flag_ener_i        [`CHANNEL_WIDTH-1:0],
    input  branch_t trellis_patterns_i [`NUM_PATTERNS-1:0][`PATTERN_DEPTH-1:0],
    output adjust_t symbol_adjust_o    [`CHANNEL_WIDTH-1:0]
);

    localparam int NUM_SUB = `CHANNEL_WIDTH / `SUBFRAME_WIDTH;
    localparam int PIDX_W  = $clog2(`NUM_PATTERNS);
    localparam int LIDX_W  = $clog2(`SUBFRAME_WIDTH);

    always_comb begin
        logic              found;
        logic [LIDX_W-1:0] win;
        energy_t           win_ener;
        flag_t             win_flag;
        logic [PIDX_W-1:0] pat;
        logic              neg;

        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            symbol_adjust_o[i] = '0;
        end

        for (int s = 0; s < NUM_SUB; s++) begin
            found    = 1'b0;
            win      = '0;
            win_ener = '0;
            win_flag = '0;

            // scan upward so an equal energy never displaces a lower lane
            for (int i = 0; i < `SUBFRAME_WIDTH; i++) begin
                if (flags_i[s*`SUBFRAME_WIDTH + i] != '0 &&
                    (!found || flag_ener_i[s*`SUBFRAME_WIDTH + i] > win_ener)) begin
                    found    = 1'b1;
                    win      = LIDX_W'(i);
                    win_ener = flag_ener_i[s*`SUBFRAME_WIDTH + i];
                    win_flag = flags_i[s*`SUBFRAME_WIDTH + i];
                end
            end

            // odd codes are positive, even codes negative
            pat = PIDX_W'((win_flag - 1'b1) >> 1);
            neg = ~win_flag[0];

            if (found) begin
                for (int k = 0; k < `PATTERN_DEPTH; k++) begin
                    if (int'(win) + k < `SUBFRAME_WIDTH) begin
                        symbol_adjust_o[s*`SUBFRAME_WIDTH + int'(win) + k] =
                            neg ? adjust_t'(-trellis_patterns_i[pat][k])
                                : adjust_t'(trellis_patterns_i[pat][k]);
                    end
                end
            end
        end
    end

endmodule : symbol_adjust_locator

// File: logic/symbol_adjust_locator_datapath.sv
`include "seq_consts.svh"

module symbol_adjust_locator_datapath
    import symbol_pkg::*, error_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  flag_t      flags_i            [`CHANNEL_WIDTH-1:0],
    input  energy_t    flag_ener_i        [`CHANNEL_WIDTH-1:0],
    input  symbol_t    symbols_i          [`CHANNEL_WIDTH-1:0],
    input  res_error_t res_errors_i       [`CHANNEL_WIDTH-1:0],
    input  branch_t    trellis_patterns_i [`NUM_PATTERNS-1:0][`PATTERN_DEPTH-1:0],
    output logic       valid_o,
    output symbol_t    symbols_o          [`CHANNEL_WIDTH-1:0],
    output res_error_t res_errors_o       [`CHANNEL_WIDTH-1:0],
    output adjust_t    symbol_adjust_o    [`CHANNEL_WIDTH-1:0]
);

    localparam int NUM_SUB = `CHANNEL_WIDTH / `SUBFRAME_WIDTH;
    localparam int CNT_W   = $clog2(`SUBFRAME_WIDTH + 1);

    symbol_t    sym_dly [`CHANNEL_WIDTH-1:0];
    res_error_t res_dly [`CHANNEL_WIDTH-1:0];
    adjust_t    loc_adj [`CHANNEL_WIDTH-1:0];

    // the detector registers its flags once, so the raw frame waits one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                sym_dly[i] <= '0;
                res_dly[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                sym_dly[i] <= symbols_i[i];
                res_dly[i] <= res_errors_i[i];
            end
        end
    end

    symbol_adjust_locator u_symbol_adjust_locator (
        .flags_i           (flags_i),
        .flag_ener_i       (flag_ener_i),
        .trellis_patterns_i(trellis_patterns_i),
        .symbol_adjust_o   (loc_adj)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                symbols_o[i]       <= '0;
                res_errors_o[i]    <= '0;
                symbol_adjust_o[i] <= '0;
            end
        end else begin
            valid_o <= valid_i;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                symbols_o[i]       <= sym_dly[i];
                res_errors_o[i]    <= res_dly[i];
                symbol_adjust_o[i] <= loc_adj[i];
            end
        end
    end

    for (genvar s = 0; s < NUM_SUB; s++) begin : g_sub_check
        logic [CNT_W-1:0] nz_cnt;

        always_comb begin
            nz_cnt = '0;
            for (int i = 0; i < `SUBFRAME_WIDTH; i++) begin
                if (symbol_adjust_o[s*`SUBFRAME_WIDTH + i] != '0) begin
                    nz_cnt = nz_cnt + 1'b1;
                end
            end
        end

        // only one pattern may be expanded in a subframe
        a_one_pattern_per_sub: assert property (@(posedge clk) disable iff (!rst_n_i)
            nz_cnt <= CNT_W'(`PATTERN_DEPTH));
    end

endmodule : symbol_adjust_locator_datapath

// File: logic/symbol_corrector.sv
`include "seq_consts.svh"

module symbol_corrector
    import symbol_pkg::*, error_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  symbol_t    symbols_i       [`CHANNEL_WIDTH-1:0],
    input  res_error_t res_errors_i    [`CHANNEL_WIDTH-1:0],
    input  adjust_t    symbol_adjust_i [`CHANNEL_WIDTH-1:0],
    output logic       valid_o,
    output symbol_t    symbols_o       [`CHANNEL_WIDTH-1:0],
    output res_error_t res_errors_o    [`CHANNEL_WIDTH-1:0],
    output adjust_t    symbol_adjust_o [`CHANNEL_WIDTH-1:0]
);

    logic signed [3:0] sum      [`CHANNEL_WIDTH-1:0];
    symbol_t           corr_sym [`CHANNEL_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            sum[i] = $signed({2'b00, symbols_i[i]})
                   + $signed({{2{symbol_adjust_i[i][1]}}, symbol_adjust_i[i]});
            // clamp back into the symbol alphabet
            if (sum[i] < 0) begin
                corr_sym[i] = 2'd0;
            end else if (sum[i] > 4'sd3) begin
                corr_sym[i] = 2'd3;
            end else begin
                corr_sym[i] = sum[i][1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                symbols_o[i]       <= '0;
                res_errors_o[i]    <= '0;
                symbol_adjust_o[i] <= '0;
            end
        end else begin
            valid_o <= valid_i;
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                symbols_o[i]       <= corr_sym[i];
                res_errors_o[i]    <= res_errors_i[i];
                symbol_adjust_o[i] <= symbol_adjust_i[i];
            end
        end
    end

    for (genvar l = 0; l < `CHANNEL_WIDTH; l++) begin : g_lane_check
        a_untouched_lane: assert property (@(posedge clk) disable iff (!rst_n_i)
            (valid_i && symbol_adjust_i[l] == '0) |=> (symbols_o[l] == $past(symbols_i[l])));
    end

endmodule : symbol_corrector

// File: logic/symbol_pkg.sv
`include "seq_consts.svh"

package symbol_pkg;

    // detected symbol, 0 to 3
    typedef logic [1:0] symbol_t;

    // correction applied to a symbol, -1 to 1
    typedef logic signed [1:0] adjust_t;

    // one weight of a trellis error pattern, -1 to 1
    typedef logic signed [1:0] branch_t;

    // 0 is no flag, 2p+1 is pattern p positive, 2p+2 is pattern p negative
    typedef logic [`FLAG_WIDTH-1:0] flag_t;

endpackage : symbol_pkg

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f \
    --top-module sequence_correction_tb -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: verilog.f
+incdir+logic
logic/symbol_pkg.sv
logic/error_pkg.sv
logic/error_flag_detector.sv
logic/symbol_adjust_locator.sv
logic/symbol_adjust_locator_datapath.sv
logic/symbol_corrector.sv
logic/sequence_correction_top.sv
dv/sequence_correction_tb.sv
